// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_m6502
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   typedef struct packed {
      addr_t addr;
      data_t wr_data;
      logic  rd_req;
      logic  wr_en;
   } bus_req_t;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
   } flags_t;

endpackage

// ==== common/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

   typedef enum logic [4:0] {
      OP_NOP,
      OP_LDA,
      OP_LDX,
      OP_LDY,
      OP_STA,
      OP_STX,
      OP_STY,
      OP_ADC,
      OP_SBC,
      OP_AND,
      OP_ORA,
      OP_EOR,
      OP_INX,
      OP_INY,
      OP_DEX,
      OP_DEY,
      OP_TAX,
      OP_TAY,
      OP_TXA,
      OP_TYA,
      OP_CLC,
      OP_SEC,
      OP_BRANCH,
      OP_JMP
   } op_t;

   typedef enum logic [1:0] {MODE_IMPLIED, MODE_IMM, MODE_ABS, MODE_REL} mode_t;

   typedef enum logic [1:0] {SEL_A, SEL_X, SEL_Y, SEL_NONE} reg_sel_t;

   typedef struct packed {
      op_t        op;
      mode_t      mode;
      reg_sel_t   dst;
      reg_sel_t   src;
      logic [2:0] cond;   // Opcode bits 7:5 of a branch
   } decoded_t;

endpackage

// ==== design/m6502_core.sv ====
`timescale 1ns/100ps

module m6502_core
   import cpu_bus_pkg::*, cpu_isa_pkg::*;
#(
   parameter addr_t RESET_VECTOR = 16'hFFFC
)
(
   input  logic  clk,
   input  logic  reset_n,
   output addr_t addr,
   input  data_t rd_data,
   output data_t wr_data,
   output logic  rd_req,
   output logic  wr_en,
   input  logic  ready
);

   bus_req_t bus;
   decoded_t dec;
   flags_t   flags;
   addr_t    pc;
   addr_t    target;
   data_t    opcode;
   data_t    operand;
   data_t    a_in;
   data_t    b_in;
   data_t    result;
   data_t    store_data;
   logic     pc_inc;
   logic     pc_load;
   logic     pc_vector;
   logic     branch_step;
   logic     alu_exec;
   logic     reg_write;
   logic     flag_set;
   logic     flag_clr;

   assign addr    = bus.addr;
   assign wr_data = bus.wr_data;
   assign rd_req  = bus.rd_req;
   assign wr_en   = bus.wr_en;

   m6502_sequencer #(
      .RESET_VECTOR (RESET_VECTOR)
   ) i_sequencer (
      .clk         (clk),
      .reset_n     (reset_n),
      .rd_data     (rd_data),
      .ready       (ready),
      .dec         (dec),
      .pc          (pc),
      .store_data  (store_data),
      .bus         (bus),
      .opcode      (opcode),
      .operand     (operand),
      .target      (target),
      .pc_inc      (pc_inc),
      .pc_load     (pc_load),
      .pc_vector   (pc_vector),
      .branch_step (branch_step),
      .alu_exec    (alu_exec),
      .reg_write   (reg_write),
      .flag_set    (flag_set),
      .flag_clr    (flag_clr)
   );

   m6502_pc i_pc (
      .clk         (clk),
      .reset_n     (reset_n),
      .pc_inc      (pc_inc),
      .pc_load     (pc_load),
      .pc_vector   (pc_vector),
      .branch_step (branch_step),
      .target      (target),
      .operand     (operand),
      .dec         (dec),
      .flags       (flags),
      .pc          (pc)
   );

   m6502_decode i_decode (
      .opcode (opcode),
      .dec    (dec)
   );

   m6502_alu i_alu (
      .clk      (clk),
      .reset_n  (reset_n),
      .alu_exec (alu_exec),
      .flag_set (flag_set),
      .flag_clr (flag_clr),
      .dec      (dec),
      .a_in     (a_in),
      .b_in     (b_in),
      .result   (result),
      .flags    (flags)
   );

   m6502_regs i_regs (
      .clk        (clk),
      .reset_n    (reset_n),
      .reg_write  (reg_write),
      .dec        (dec),
      .operand    (operand),
      .result     (result),
      .a_in       (a_in),
      .b_in       (b_in),
      .store_data (store_data)
   );

endmodule

// ==== design/m6502_decode.sv ====
`timescale 1ns/100ps

module m6502_decode
   import cpu_bus_pkg::*, cpu_isa_pkg::*;
(
   input  data_t    opcode,
   output decoded_t dec
);

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;
   reg_sel_t   idx;
   decoded_t   nop;

   assign aaa = opcode[7:5];
   assign bbb = opcode[4:2];
   assign cc  = opcode[1:0];
   assign idx = cc[1] ? SEL_X : SEL_Y;   // cc 10 is the X group, 00 the Y group
   assign nop = '{op: OP_NOP, mode: MODE_IMPLIED, dst: SEL_NONE, src: SEL_NONE, cond: aaa};

   always_comb
   begin
      dec = nop;
      if (cc == 2'b01 && (bbb == 3'b010 || bbb == 3'b011))
      begin
         dec.mode = bbb[0] ? MODE_ABS : MODE_IMM;
         dec.src  = SEL_A;
         dec.dst  = SEL_A;
         case (aaa)
            3'b000: dec.op = OP_ORA;
            3'b001: dec.op = OP_AND;
            3'b010: dec.op = OP_EOR;
            3'b011: dec.op = OP_ADC;
            3'b101:
            begin
               dec.op  = OP_LDA;
               dec.src = SEL_NONE;
            end
            3'b111: dec.op = OP_SBC;
            default: dec = nop;   // CMP
         endcase
         if (aaa == 3'b100 && bbb[0])
         begin
            dec.op   = OP_STA;
            dec.mode = MODE_ABS;
            dec.src  = SEL_A;
            dec.dst  = SEL_NONE;
         end
      end
      else if (cc == 2'b00 && bbb == 3'b100 && aaa[2])
      begin
         dec.op   = OP_BRANCH;
         dec.mode = MODE_REL;
      end
      else if (opcode == 8'h18 || opcode == 8'h38)
      begin
         dec.op = aaa[0] ? OP_SEC : OP_CLC;
      end
      else if (opcode == 8'h4C)
      begin
         dec.op   = OP_JMP;
         dec.mode = MODE_ABS;
      end
      else if (opcode == 8'h98)
      begin
         dec.op  = OP_TYA;
         dec.src = SEL_Y;
         dec.dst = SEL_A;
      end
      else if (!cc[0])
      begin
         case ({aaa, bbb})
            6'b100_011:
            begin
               dec.op   = cc[1] ? OP_STX : OP_STY;
               dec.mode = MODE_ABS;
               dec.src  = idx;
            end
            6'b101_000, 6'b101_011:
            begin
               dec.op   = cc[1] ? OP_LDX : OP_LDY;
               dec.mode = bbb[0] ? MODE_ABS : MODE_IMM;
               dec.dst  = idx;
            end
            6'b100_010:
            begin
               dec.op  = cc[1] ? OP_TXA : OP_DEY;
               dec.src = idx;
               dec.dst = cc[1] ? SEL_A : SEL_Y;
            end
            6'b101_010:
            begin
               dec.op  = cc[1] ? OP_TAX : OP_TAY;
               dec.src = SEL_A;
               dec.dst = idx;
            end
            6'b110_010:
            begin
               dec.op  = cc[1] ? OP_DEX : OP_INY;
               dec.src = idx;
               dec.dst = idx;
            end
            6'b111_010:
               if (!cc[1])
               begin
                  dec.op  = OP_INX;
                  dec.src = SEL_X;
                  dec.dst = SEL_X;
               end
            default:
               dec = nop;
         endcase
      end
   end

endmodule

// ==== design/m6502_pc.sv ====
`timescale 1ns/100ps

module m6502_pc
   import cpu_bus_pkg::*, cpu_isa_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   input  logic     pc_inc,
   input  logic     pc_load,
   input  logic     pc_vector,
   input  logic     branch_step,
   input  addr_t    target,
   input  data_t    operand,
   input  decoded_t dec,
   input  flags_t   flags,
   output addr_t    pc
);

   logic flag_bit;
   logic taken;

   // 6502 branch encoding, bits 7:6 pick the flag and bit 5 the value
   always_comb
   begin
      case (dec.cond[2:1])
         2'b00:   flag_bit = flags.n;
         2'b10:   flag_bit = flags.c;
         2'b11:   flag_bit = flags.z;
         default: flag_bit = 1'b0;   // No V flag
      endcase
   end

   assign taken = (flag_bit == dec.cond[0]);

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         pc <= '0;
      end
      else if (pc_vector || pc_load)
      begin
         pc <= target;
      end
      else if (branch_step && taken)
      begin
         pc <= pc + {{8{operand[7]}}, operand};   // Signed offset
      end
      else if (pc_inc)
      begin
         pc <= pc + 16'd1;
      end
   end

endmodule

// ==== design/m6502_sequencer.sv ====
`timescale 1ns/100ps

module m6502_sequencer
   import cpu_bus_pkg::*, cpu_isa_pkg::*;
#(
   parameter addr_t RESET_VECTOR = 16'hFFFC
)
(
   input  logic     clk,
   input  logic     reset_n,
   input  data_t    rd_data,
   input  logic     ready,
   input  decoded_t dec,
   input  addr_t    pc,
   input  data_t    store_data,
   output bus_req_t bus,
   output data_t    opcode,
   output data_t    operand,
   output addr_t    target,
   output logic     pc_inc,
   output logic     pc_load,
   output logic     pc_vector,
   output logic     branch_step,
   output logic     alu_exec,
   output logic     reg_write,
   output logic     flag_set,
   output logic     flag_clr
);

   typedef enum logic [2:0] {
      VECTOR_LO,
      VECTOR_HI,
      FETCH,
      OPERAND_LO,
      OPERAND_HI,
      DATA_READ,
      DATA_WRITE,
      EXECUTE
   } seq_state_t;

   seq_state_t state;
   logic       opcode_valid;   // Opcode latched, not yet dispatched
   logic       done;
   logic       is_jmp;
   logic       is_store;

   function automatic bus_req_t read_req(input addr_t a);
      bus_req_t r;
      r = '0;
      r.addr   = a;
      r.rd_req = 1'b1;
      return r;
   endfunction

   function automatic bus_req_t write_req(input addr_t a, input data_t d);
      bus_req_t r;
      r = '0;
      r.addr    = a;
      r.wr_data = d;
      r.wr_en   = 1'b1;
      return r;
   endfunction

   assign done     = ready && (bus.rd_req || bus.wr_en);
   assign is_jmp   = (dec.op == OP_JMP);
   assign is_store = (dec.op == OP_STA) || (dec.op == OP_STX) || (dec.op == OP_STY);

   // High byte is taken straight off the bus at the end of the second read
   assign target = {rd_data, operand};

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state        <= VECTOR_LO;
         bus          <= '0;
         opcode_valid <= 1'b0;
      end
      else
      begin
         case (state)
            VECTOR_LO:
               if (!bus.rd_req)
               begin
                  bus <= read_req(RESET_VECTOR);
               end
               else if (ready)
               begin
                  bus   <= read_req(RESET_VECTOR + 16'd1);
                  state <= VECTOR_HI;
               end
            VECTOR_HI:
               if (ready)
               begin
                  bus   <= read_req(target);
                  state <= FETCH;
               end
            FETCH:
               if (bus.rd_req)
               begin
                  if (ready)
                  begin
                     bus          <= '0;
                     opcode_valid <= 1'b1;
                  end
               end
               else if (!opcode_valid)
               begin
                  bus <= read_req(pc);   // Refetch after a branch
               end
               else
               begin
                  opcode_valid <= 1'b0;
                  if (dec.mode == MODE_IMPLIED)
                  begin
                     state <= EXECUTE;
                  end
                  else
                  begin
                     bus   <= read_req(pc);
                     state <= OPERAND_LO;
                  end
               end
            OPERAND_LO:
               if (ready)
               begin
                  if (dec.mode == MODE_ABS)
                  begin
                     bus   <= read_req(pc + 16'd1);   // pc steps at this edge
                     state <= OPERAND_HI;
                  end
                  else
                  begin
                     bus   <= '0;
                     state <= EXECUTE;
                  end
               end
            OPERAND_HI:
               if (ready)
               begin
                  if (is_jmp)
                  begin
                     bus   <= '0;
                     state <= EXECUTE;
                  end
                  else if (is_store)
                  begin
                     bus   <= write_req(target, store_data);
                     state <= DATA_WRITE;
                  end
                  else
                  begin
                     bus   <= read_req(target);
                     state <= DATA_READ;
                  end
               end
            DATA_READ, DATA_WRITE:
               if (ready)
               begin
                  bus   <= '0;
                  state <= EXECUTE;
               end
            EXECUTE:
            begin
               // Branch target is known one cycle later
               if (dec.mode != MODE_REL)
               begin
                  bus <= read_req(pc);
               end
               state <= FETCH;
            end
            default:
               state <= VECTOR_LO;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (bus.rd_req && ready)
      begin
         case (state)
            FETCH:
               opcode <= rd_data;
            VECTOR_LO, OPERAND_LO, DATA_READ:
               operand <= rd_data;
            default:
               ;
         endcase
      end
   end

   always_comb
   begin
      pc_inc      = 1'b0;
      pc_load     = 1'b0;
      pc_vector   = 1'b0;
      branch_step = 1'b0;
      alu_exec    = 1'b0;
      reg_write   = 1'b0;
      flag_set    = 1'b0;
      flag_clr    = 1'b0;
      case (state)
         VECTOR_HI:
            pc_vector = done;
         FETCH, OPERAND_LO:
            pc_inc = done;
         OPERAND_HI:
         begin
            pc_load = done && is_jmp;
            pc_inc  = done && !is_jmp;
         end
         EXECUTE:
         begin
            branch_step = (dec.op == OP_BRANCH);
            alu_exec    = (dec.dst != SEL_NONE);
            reg_write   = (dec.dst != SEL_NONE);
            flag_set    = (dec.op == OP_SEC);
            flag_clr    = (dec.op == OP_CLC);
         end
         default:
            ;
      endcase
   end

endmodule

// ==== execute/m6502_alu.sv ====
`timescale 1ns/100ps

module m6502_alu
   import cpu_bus_pkg::*, cpu_isa_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   input  logic     alu_exec,
   input  logic     flag_set,
   input  logic     flag_clr,
   input  decoded_t dec,
   input  data_t    a_in,
   input  data_t    b_in,
   output data_t    result,
   output flags_t   flags
);

   data_t      addend;
   logic [8:0] sum;
   logic       carry_op;

   // SBC is A + ~M + C
   assign addend   = (dec.op == OP_SBC) ? ~b_in : b_in;
   assign sum      = {1'b0, a_in} + {1'b0, addend} + {8'd0, flags.c};
   assign carry_op = (dec.op == OP_ADC) || (dec.op == OP_SBC);

   always_comb
   begin
      case (dec.op)
         OP_ADC, OP_SBC:                 result = sum[7:0];
         OP_AND:                         result = a_in & b_in;
         OP_ORA:                         result = a_in | b_in;
         OP_EOR:                         result = a_in ^ b_in;
         OP_INX, OP_INY:                 result = a_in + 8'd1;
         OP_DEX, OP_DEY:                 result = a_in - 8'd1;
         OP_TAX, OP_TAY, OP_TXA, OP_TYA: result = a_in;
         default:                        result = b_in;   // Loads
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         flags <= '0;
      end
      else
      begin
         if (alu_exec)
         begin
            flags.n <= result[7];
            flags.z <= (result == 8'h00);
         end
         if (alu_exec && carry_op)
         begin
            flags.c <= sum[8];
         end
         else if (flag_set)
         begin
            flags.c <= 1'b1;
         end
         else if (flag_clr)
         begin
            flags.c <= 1'b0;
         end
      end
   end

endmodule

// ==== execute/m6502_regs.sv ====
`timescale 1ns/100ps

module m6502_regs
   import cpu_bus_pkg::*, cpu_isa_pkg::*;
(
   input  logic     clk,
   input  logic     reset_n,
   input  logic     reg_write,
   input  decoded_t dec,
   input  data_t    operand,
   input  data_t    result,
   output data_t    a_in,
   output data_t    b_in,
   output data_t    store_data
);

   data_t reg_a;
   data_t reg_x;
   data_t reg_y;

   always_comb
   begin
      case (dec.src)
         SEL_A:   a_in = reg_a;
         SEL_X:   a_in = reg_x;
         SEL_Y:   a_in = reg_y;
         default: a_in = 8'h00;
      endcase
   end

   assign b_in = operand;   // Immediate byte or data read

   always_comb
   begin
      case (dec.op)
         OP_STX:  store_data = reg_x;
         OP_STY:  store_data = reg_y;
         default: store_data = reg_a;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         reg_a <= '0;
         reg_x <= '0;
         reg_y <= '0;
      end
      else if (reg_write)
      begin
         case (dec.dst)
            SEL_A:   reg_a <= result;
            SEL_X:   reg_x <= result;
            SEL_Y:   reg_y <= result;
            default: ;
         endcase
      end
   end

endmodule

// ==== src.f ====
common/cpu_bus_pkg.sv
common/cpu_isa_pkg.sv
design/m6502_decode.sv
design/m6502_pc.sv
design/m6502_sequencer.sv
execute/m6502_alu.sv
execute/m6502_regs.sv
design/m6502_core.sv
testbench/m6502_asserts.sv
testbench/tb_m6502.sv

// ==== testbench/m6502_asserts.sv ====
`timescale 1ns/100ps

module m6502_asserts
   import cpu_bus_pkg::*;
(
   input logic  clk,
   input logic  reset_n,
   input addr_t addr,
   input data_t rd_data,
   input data_t wr_data,
   input logic  rd_req,
   input logic  wr_en,
   input logic  ready
);

   localparam addr_t VECTOR_LO_ADDR = 16'hFFFC;
   localparam addr_t VECTOR_HI_ADDR = 16'hFFFD;
   localparam addr_t PROGRAM_START  = 16'h0400;
   localparam addr_t END_ADDR       = 16'h0200;
   localparam data_t END_VALUE      = 8'hA5;
   localparam addr_t SKIP_ADDR      = 16'h0230;   // Only reachable by a wrong branch or jump

   int unsigned fail_count = 0;
   logic [1:0]  rd_count;
   logic [15:0] slot_written;   // One bit per result slot

   // Expected byte for each result slot 0210 to 021F
   function automatic data_t expected_result(input logic [3:0] slot);
      case (slot)
         4'h0:    return 8'h11;
         4'h1:    return 8'h22;
         4'h2:    return 8'h33;
         4'h3:    return 8'h3C;
         4'h4:    return 8'hC3;
         4'h5:    return 8'h5A;
         4'h6:    return 8'h8C;   // 3C + 50
         4'h7:    return 8'h80;   // 8C - 0C
         4'h8:    return 8'h70;
         4'h9:    return 8'h10;   // Carry out of 70 + A0
         4'hA:    return 8'hF0;   // Borrow from 10 - 20
         4'hB:    return 8'hC4;
         4'hC:    return 8'h59;
         4'hD:    return 8'h7E;
         4'hE:    return 8'h7F;
         default: return 8'h05;   // Loop count
      endcase
   endfunction

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         rd_count     <= '0;
         slot_written <= '0;
      end
      else
      begin
         if (rd_req && ready && rd_count != 2'd3)
         begin
            rd_count <= rd_count + 2'd1;
         end
         if (wr_en && ready && addr[15:4] == 12'h021)
         begin
            slot_written[addr[3:0]] <= 1'b1;
         end
      end
   end

   vector_reads: assert property (@(posedge clk) disable iff (!reset_n)
      rd_req |-> (rd_count == 2'd0) ? (addr == VECTOR_LO_ADDR) :
                 (rd_count == 2'd1) ? (addr == VECTOR_HI_ADDR) :
                 (rd_count == 2'd2) ? (addr == PROGRAM_START) : 1'b1)
      else
      begin
         $error("ERROR %0t: wrong reset vector read sequence, addr %h", $time, addr);
         fail_count++;
      end

   result_values: assert property (@(posedge clk) disable iff (!reset_n)
      (wr_en && ready && addr[15:4] == 12'h021) |-> wr_data == expected_result(addr[3:0]))
      else
      begin
         $error("ERROR %0t: store to %h wrote %h", $time, addr, wr_data);
         fail_count++;
      end

   end_value: assert property (@(posedge clk) disable iff (!reset_n)
      (wr_en && addr == END_ADDR) |-> (wr_data == END_VALUE && slot_written == 16'hFFFF))
      else
      begin
         $error("ERROR %0t: end marker store wrote %h with result slots %h written",
                $time, wr_data, slot_written);
         fail_count++;
      end

   skipped_store: assert property (@(posedge clk) disable iff (!reset_n)
      !(wr_en && addr == SKIP_ADDR))
      else
      begin
         $error("ERROR %0t: skipped store to %h was executed", $time, addr);
         fail_count++;
      end

   read_stable: assert property (@(posedge clk) disable iff (!reset_n)
      (rd_req && !ready) |=> (rd_req && !wr_en && $stable(addr)))
      else
      begin
         $error("ERROR %0t: read request changed while waiting", $time);
         fail_count++;
      end

   write_stable: assert property (@(posedge clk) disable iff (!reset_n)
      (wr_en && !ready) |=> (wr_en && !rd_req && $stable(addr) && $stable(wr_data)))
      else
      begin
         $error("ERROR %0t: write request changed while waiting", $time);
         fail_count++;
      end

   one_request: assert property (@(posedge clk) !(rd_req && wr_en))
      else
      begin
         $error("ERROR %0t: read and write requested together", $time);
         fail_count++;
      end

endmodule

// ==== testbench/tb_m6502.sv ====
`timescale 1ns/100ps

module tb_m6502
   import cpu_bus_pkg::*;
;

   localparam int    PROGRAM_CYCLES = 600;   // Worst case with random waits
   localparam int    TIMEOUT_CYCLES = 10 * PROGRAM_CYCLES;
   localparam addr_t PROGRAM_START  = 16'h0400;

   logic  clk;
   logic  reset_n;
   logic  ready;
   data_t rd_data;
   addr_t addr;
   data_t wr_data;
   logic  rd_req;
   logic  wr_en;

   data_t       mem [0:65535];
   data_t       program_bytes [$];
   logic [31:0] lfsr_state;
   int          cycle;
   logic        finished;

   m6502_core #(
      .RESET_VECTOR (16'hFFFC)
   ) i_dut (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .rd_req  (rd_req),
      .wr_en   (wr_en),
      .ready   (ready)
   );

   bind m6502_core m6502_asserts i_asserts (.*);

   // Galois LFSR, one step per bit
   function automatic logic next_random_bit();
      logic lsb;
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb)
      begin
         lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      return lsb;
   endfunction

   task automatic load_memory();
      for (int i = 0; i < 65536; i++)
      begin
         mem[i] = data_t'(i) ^ data_t'(i >> 8) ^ 8'h5A;
      end
      mem[16'hFFFC] = PROGRAM_START[7:0];
      mem[16'hFFFD] = PROGRAM_START[15:8];
      mem[16'h0300] = 8'h3C;
      mem[16'h0301] = 8'hC3;
      mem[16'h0302] = 8'h5A;
      program_bytes = {
         8'hA9, 8'h11, 8'h8D, 8'h10, 8'h02,          // LDA #, STA
         8'hA2, 8'h22, 8'h8E, 8'h11, 8'h02,          // LDX #, STX
         8'hA0, 8'h33, 8'h8C, 8'h12, 8'h02,          // LDY #, STY
         8'hAD, 8'h00, 8'h03, 8'h8D, 8'h13, 8'h02,   // LDA abs
         8'hAE, 8'h01, 8'h03, 8'h8E, 8'h14, 8'h02,
         8'hAC, 8'h02, 8'h03, 8'h8C, 8'h15, 8'h02,
         8'h18, 8'h69, 8'h50, 8'h8D, 8'h16, 8'h02,   // CLC, ADC
         8'h38, 8'hE9, 8'h0C, 8'h8D, 8'h17, 8'h02,   // SEC, SBC
         8'h29, 8'hF0, 8'h09, 8'h0F, 8'h49, 8'hFF,
         8'h8D, 8'h18, 8'h02,
         8'h18, 8'h69, 8'hA0, 8'hB0, 8'h02,          // BCS over the wrong value
         8'hA9, 8'hEE, 8'h8D, 8'h19, 8'h02,
         8'h38, 8'hE9, 8'h20, 8'h90, 8'h02,          // BCC over the wrong value
         8'hA9, 8'hEE, 8'h8D, 8'h1A, 8'h02,
         8'hE8, 8'h88, 8'h8A, 8'h8D, 8'h1B, 8'h02,   // INX, DEY, TXA
         8'h98, 8'h8D, 8'h1C, 8'h02,
         8'hA9, 8'h7E, 8'hAA, 8'hA8, 8'hC8,          // TAX, TAY, INY
         8'h8E, 8'h1D, 8'h02, 8'h8C, 8'h1E, 8'h02,
         8'hA2, 8'h05, 8'hA0, 8'h00,                 // Loop counts Y up
         8'hC8, 8'hCA, 8'hD0, 8'hFC,
         8'h8C, 8'h1F, 8'h02,
         8'hF0, 8'h03, 8'h8E, 8'h30, 8'h02,          // BEQ over a forbidden store
         8'h4C, 8'h75, 8'h04, 8'h8D, 8'h30, 8'h02,   // JMP over a forbidden store
         8'hA9, 8'hA5, 8'h8D, 8'h00, 8'h02
      };
      foreach (program_bytes[i])
      begin
         mem[PROGRAM_START + addr_t'(i)] = program_bytes[i];
      end
   endtask

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   initial
   begin
      reset_n    = 1'b0;
      ready      = 1'b0;
      rd_data    = '0;
      lfsr_state = 32'h73e4;
      cycle      = 0;
      finished   = 1'b0;
      load_memory();
      forever
      begin
         @(posedge clk);
         #2;
         cycle++;
         if (cycle == 8)
         begin
            reset_n = 1'b1;
         end
         ready   = next_random_bit();
         rd_data = mem[addr];
      end
   end

   always @(posedge clk)
   begin
      if (reset_n && wr_en && ready)
      begin
         mem[addr] <= wr_data;
         if (addr == 16'h0200 && wr_data == 8'hA5)
         begin
            finished = 1'b1;
         end
      end
   end

   // Checked mid-cycle, once the edge's assertion results are in
   initial
   begin
      @(negedge clk);
      while (!finished && i_dut.i_asserts.fail_count == 0 && cycle < TIMEOUT_CYCLES)
      begin
         @(negedge clk);
      end
      if (finished && i_dut.i_asserts.fail_count == 0)
      begin
         $display("Test completed successfully");
         $finish;
      end
      else
      begin
         if (i_dut.i_asserts.fail_count == 0)
         begin
            $display("Timeout: the test program never finished within %0d cycles",
                     TIMEOUT_CYCLES);
         end
         $display("Test failed");
         $fatal(1, "Run stopped");
      end
   end

endmodule
